// File: Makefile
TOP := spmm_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sources.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "Run reported failure"; exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "Run ended without a verdict"; exit 1)

lint:
	verilator --lint-only -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

// File: logic/mac_array.sv
// Per-lane multiply-accumulate array
module mac_array
  import spmm_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    stall_i,
  input  logic                                    item_valid_i,
  input  logic                                    item_is_entry_i,
  input  logic signed [DATA_WIDTH-1:0]            item_val_i,
  input  logic                                    item_last_i,
  input  logic [NUM_NODE_WIDTH-1:0]               item_num_node_i,
  input  logic                                    item_src_flag_i,
  input  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]    wgt_vec_i,
  output logic                                    res_valid_o,
  output logic [NUM_LANES-1:0][WH_DATA_WIDTH-1:0] res_data_o,
  output logic [NUM_NODE_WIDTH-1:0]               res_num_node_o,
  output logic                                    res_src_flag_o
);

  logic signed [ACC_WIDTH-1:0]           acc     [NUM_LANES];
  logic signed [ACC_WIDTH-1:0]           acc_sum [NUM_LANES];
  logic [NUM_LANES-1:0][WH_DATA_WIDTH-1:0] sat_res;
  logic                                  take;

  // Clamp a lane sum into the 12-bit WH range
  function automatic logic [WH_DATA_WIDTH-1:0] saturate(
    input logic signed [ACC_WIDTH-1:0] sum
  );
    logic [WH_DATA_WIDTH-1:0] res;
    if (sum > WH_MAX) begin
      res = WH_DATA_WIDTH'(WH_MAX);
    end else if (sum < WH_MIN) begin
      res = WH_DATA_WIDTH'(WH_MIN);
    end else begin
      res = sum[WH_DATA_WIDTH-1:0];
    end
    return res;
  endfunction

  assign take = item_valid_i && !stall_i;

  // ========================================
  // Lane datapath
  // ========================================
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    logic signed [2*DATA_WIDTH-1:0] prod;

    assign prod       = item_val_i * $signed(wgt_vec_i[l]);
    // Zero-length header item passes the accumulator through
    assign acc_sum[l] = item_is_entry_i ? acc[l] + prod : acc[l];
    assign sat_res[l] = saturate(acc_sum[l]);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        acc[l] <= '0;
      end
    end else if (take) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        acc[l] <= item_last_i ? '0 : acc_sum[l];
      end
    end
  end

  // ========================================
  // Result register
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_o <= 1'b0;
    end else if (!stall_i) begin
      res_valid_o <= item_valid_i && item_last_i;
    end
  end

  always_ff @(posedge clk) begin
    if (take && item_last_i) begin
      res_data_o     <= sat_res;
      res_num_node_o <= item_num_node_i;
      res_src_flag_o <= item_src_flag_i;
    end
  end

endmodule

// File: logic/row_fetch.sv
// Sparse row fetch stage
module row_fetch
  import spmm_pkg::*;
#(
  parameter int IN_CREDITS = 8
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid_i,
  input  logic                         in_is_hdr_i,
  input  h_word_t                      in_word_i,
  input  logic                         stall_i,
  output logic                         in_credit_o,
  output logic                         item_valid_o,
  output logic                         item_is_entry_o,
  output logic [COL_IDX_WIDTH-1:0]     item_col_o,
  output logic signed [DATA_WIDTH-1:0] item_val_o,
  output logic                         item_last_o,
  output logic [NUM_NODE_WIDTH-1:0]    item_num_node_o,
  output logic                         item_src_flag_o
);
  localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
  localparam int CNT_W = $clog2(IN_CREDITS + 1);

  h_word_t                   buf_word [IN_CREDITS];
  logic                      buf_hdr  [IN_CREDITS];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [CNT_W-1:0]          fill_cnt;
  logic                      pop;
  h_word_t                   head_word;
  logic                      head_is_hdr;
  logic                      empty_row;
  logic [ROW_LEN_WIDTH-1:0]  remain;
  logic [NUM_NODE_WIDTH-1:0] cur_num_node;
  logic                      cur_src_flag;

  // ========================================
  // Credit buffer
  // ========================================
  // Sender never writes without a credit, so no full check here
  always_ff @(posedge clk) begin
    if (in_valid_i) begin
      buf_word[wr_ptr] <= in_word_i;
      buf_hdr[wr_ptr]  <= in_is_hdr_i;
    end
  end

  assign pop         = (fill_cnt != '0) && !stall_i;
  assign head_word   = buf_word[rd_ptr];
  assign head_is_hdr = buf_hdr[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fill_cnt    <= '0;
      in_credit_o <= 1'b0;
    end else begin
      if (in_valid_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill_cnt    <= fill_cnt + CNT_W'(in_valid_i) - CNT_W'(pop);
      // One credit back per popped word
      in_credit_o <= pop;
    end
  end

  // ========================================
  // Row tracking
  // ========================================
  assign empty_row = head_is_hdr && (head_word.row_hdr.row_len == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remain <= '0;
    end else if (pop) begin
      if (head_is_hdr) begin
        remain <= head_word.row_hdr.row_len;
      end else if (remain != '0) begin
        remain <= remain - 1'b1;
      end
    end
  end

  // Node info of the row in progress
  always_ff @(posedge clk) begin
    if (pop && head_is_hdr) begin
      cur_num_node <= head_word.row_hdr.num_node;
      cur_src_flag <= head_word.row_hdr.src_flag;
    end
  end

  // Non-empty headers only load context and emit no item
  assign item_valid_o    = pop && (!head_is_hdr || empty_row);
  assign item_is_entry_o = !head_is_hdr;
  assign item_col_o      = head_word.nz_entry.col_idx;
  assign item_val_o      = head_word.nz_entry.val;
  assign item_last_o     = head_is_hdr || (remain == ROW_LEN_WIDTH'(1));
  assign item_num_node_o = head_is_hdr ? head_word.row_hdr.num_node : cur_num_node;
  assign item_src_flag_o = head_is_hdr ? head_word.row_hdr.src_flag : cur_src_flag;

endmodule

// File: logic/spmm_pkg.sv
// SpMM shared definitions
package spmm_pkg;

  // ========================================
  // Element widths
  // ========================================
  localparam int DATA_WIDTH     = 8;
  localparam int NUM_FEATURE_IN = 16;
  localparam int COL_IDX_WIDTH  = 4;
  localparam int ROW_LEN_WIDTH  = 5;
  localparam int NUM_NODE_WIDTH = 8;
  localparam int WH_DATA_WIDTH  = 12;
  localparam int WH_ADDR_WIDTH  = 7;

  // Wide enough for 16 products of two 8-bit signed values
  localparam int ACC_WIDTH      = 20;

  // Saturation limits of one WH lane
  localparam int WH_MAX         = (1 << (WH_DATA_WIDTH - 1)) - 1;
  localparam int WH_MIN         = -(1 << (WH_DATA_WIDTH - 1));

  // ========================================
  // Input stream word
  // ========================================
  localparam int H_WORD_WIDTH    = ROW_LEN_WIDTH + NUM_NODE_WIDTH + 1;
  localparam int ENTRY_PAD_WIDTH = H_WORD_WIDTH - COL_IDX_WIDTH - DATA_WIDTH;

  // Kind bit on the port selects row_hdr or nz_entry
  typedef union packed {
    struct packed {
      logic [ROW_LEN_WIDTH-1:0]  row_len;
      logic [NUM_NODE_WIDTH-1:0] num_node;
      logic                      src_flag;
    } row_hdr;
    struct packed {
      logic [ENTRY_PAD_WIDTH-1:0] pad;
      logic [COL_IDX_WIDTH-1:0]   col_idx;
      logic [DATA_WIDTH-1:0]      val;
    } nz_entry;
  } h_word_t;

endpackage

// File: logic/spmm_top.sv
// Sparse-by-dense feature transform
module spmm_top
  import spmm_pkg::*;
#(
  parameter int NUM_LANES   = 4,
  parameter int IN_CREDITS  = 8,
  parameter int OUT_CREDITS = 4,
  localparam int LANE_W     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    in_valid_i,
  input  logic                                    in_is_hdr_i,
  input  h_word_t                                 in_word_i,
  output logic                                    in_credit_o,
  input  logic                                    wgt_we_i,
  input  logic [COL_IDX_WIDTH-1:0]                wgt_row_i,
  input  logic [LANE_W-1:0]                       wgt_lane_i,
  input  logic [DATA_WIDTH-1:0]                   wgt_data_i,
  input  logic                                    out_credit_i,
  output logic                                    wh_valid_o,
  output logic [NUM_LANES-1:0][WH_DATA_WIDTH-1:0] wh_data_o,
  output logic [NUM_NODE_WIDTH-1:0]               wh_num_node_o,
  output logic                                    wh_src_flag_o,
  output logic [WH_ADDR_WIDTH-1:0]                wh_addr_o
);

  logic                                    stall;

  // Fetch to lookup
  logic                                    fch_valid;
  logic                                    fch_is_entry;
  logic [COL_IDX_WIDTH-1:0]                fch_col;
  logic signed [DATA_WIDTH-1:0]            fch_val;
  logic                                    fch_last;
  logic [NUM_NODE_WIDTH-1:0]               fch_num_node;
  logic                                    fch_src_flag;

  // Lookup to MAC
  logic                                    lk_valid;
  logic                                    lk_is_entry;
  logic signed [DATA_WIDTH-1:0]            lk_val;
  logic                                    lk_last;
  logic [NUM_NODE_WIDTH-1:0]               lk_num_node;
  logic                                    lk_src_flag;
  logic [NUM_LANES-1:0][DATA_WIDTH-1:0]    lk_wgt_vec;

  // MAC to writer
  logic                                    res_valid;
  logic [NUM_LANES-1:0][WH_DATA_WIDTH-1:0] res_data;
  logic [NUM_NODE_WIDTH-1:0]               res_num_node;
  logic                                    res_src_flag;

  row_fetch #(
    .IN_CREDITS (IN_CREDITS)
  ) u_row_fetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid_i      (in_valid_i),
    .in_is_hdr_i     (in_is_hdr_i),
    .in_word_i       (in_word_i),
    .stall_i         (stall),
    .in_credit_o     (in_credit_o),
    .item_valid_o    (fch_valid),
    .item_is_entry_o (fch_is_entry),
    .item_col_o      (fch_col),
    .item_val_o      (fch_val),
    .item_last_o     (fch_last),
    .item_num_node_o (fch_num_node),
    .item_src_flag_o (fch_src_flag)
  );

  weight_lookup #(
    .NUM_LANES (NUM_LANES)
  ) u_weight_lookup (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_we_i        (wgt_we_i),
    .wgt_row_i       (wgt_row_i),
    .wgt_lane_i      (wgt_lane_i),
    .wgt_data_i      (wgt_data_i),
    .stall_i         (stall),
    .item_valid_i    (fch_valid),
    .item_is_entry_i (fch_is_entry),
    .item_col_i      (fch_col),
    .item_val_i      (fch_val),
    .item_last_i     (fch_last),
    .item_num_node_i (fch_num_node),
    .item_src_flag_i (fch_src_flag),
    .item_valid_o    (lk_valid),
    .item_is_entry_o (lk_is_entry),
    .item_val_o      (lk_val),
    .item_last_o     (lk_last),
    .item_num_node_o (lk_num_node),
    .item_src_flag_o (lk_src_flag),
    .wgt_vec_o       (lk_wgt_vec)
  );

  mac_array #(
    .NUM_LANES (NUM_LANES)
  ) u_mac_array (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall_i         (stall),
    .item_valid_i    (lk_valid),
    .item_is_entry_i (lk_is_entry),
    .item_val_i      (lk_val),
    .item_last_i     (lk_last),
    .item_num_node_i (lk_num_node),
    .item_src_flag_i (lk_src_flag),
    .wgt_vec_i       (lk_wgt_vec),
    .res_valid_o     (res_valid),
    .res_data_o      (res_data),
    .res_num_node_o  (res_num_node),
    .res_src_flag_o  (res_src_flag)
  );

  wh_writer #(
    .NUM_LANES   (NUM_LANES),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_wh_writer (
    .clk            (clk),
    .rst_n          (rst_n),
    .res_valid_i    (res_valid),
    .res_data_i     (res_data),
    .res_num_node_i (res_num_node),
    .res_src_flag_i (res_src_flag),
    .out_credit_i   (out_credit_i),
    .stall_o        (stall),
    .wh_valid_o     (wh_valid_o),
    .wh_data_o      (wh_data_o),
    .wh_num_node_o  (wh_num_node_o),
    .wh_src_flag_o  (wh_src_flag_o),
    .wh_addr_o      (wh_addr_o)
  );

endmodule

// File: logic/weight_lookup.sv
// Weight memory and lookup stage
module weight_lookup
  import spmm_pkg::*;
#(
  parameter int NUM_LANES = 4,
  localparam int LANE_W   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 wgt_we_i,
  input  logic [COL_IDX_WIDTH-1:0]             wgt_row_i,
  input  logic [LANE_W-1:0]                    wgt_lane_i,
  input  logic [DATA_WIDTH-1:0]                wgt_data_i,
  input  logic                                 stall_i,
  input  logic                                 item_valid_i,
  input  logic                                 item_is_entry_i,
  input  logic [COL_IDX_WIDTH-1:0]             item_col_i,
  input  logic signed [DATA_WIDTH-1:0]         item_val_i,
  input  logic                                 item_last_i,
  input  logic [NUM_NODE_WIDTH-1:0]            item_num_node_i,
  input  logic                                 item_src_flag_i,
  output logic                                 item_valid_o,
  output logic                                 item_is_entry_o,
  output logic signed [DATA_WIDTH-1:0]         item_val_o,
  output logic                                 item_last_o,
  output logic [NUM_NODE_WIDTH-1:0]            item_num_node_o,
  output logic                                 item_src_flag_o,
  output logic [NUM_LANES-1:0][DATA_WIDTH-1:0] wgt_vec_o
);

  // One row per input feature, one lane slot per output feature
  logic [NUM_LANES-1:0][DATA_WIDTH-1:0] wgt_mem [NUM_FEATURE_IN];

  // ========================================
  // Load port
  // ========================================
  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_mem[wgt_row_i][wgt_lane_i] <= wgt_data_i;
    end
  end

  // ========================================
  // Lookup register
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      item_valid_o <= 1'b0;
    end else if (!stall_i) begin
      item_valid_o <= item_valid_i;
    end
  end

  // Whole weight row read at the entry column, for all lanes at once
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      item_is_entry_o <= item_is_entry_i;
      item_val_o      <= item_val_i;
      item_last_o     <= item_last_i;
      item_num_node_o <= item_num_node_i;
      item_src_flag_o <= item_src_flag_i;
      wgt_vec_o       <= wgt_mem[item_col_i];
    end
  end

endmodule

// File: logic/wh_writer.sv
// WH result writer with output credits
module wh_writer
  import spmm_pkg::*;
#(
  parameter int NUM_LANES   = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    res_valid_i,
  input  logic [NUM_LANES-1:0][WH_DATA_WIDTH-1:0] res_data_i,
  input  logic [NUM_NODE_WIDTH-1:0]               res_num_node_i,
  input  logic                                    res_src_flag_i,
  input  logic                                    out_credit_i,
  output logic                                    stall_o,
  output logic                                    wh_valid_o,
  output logic [NUM_LANES-1:0][WH_DATA_WIDTH-1:0] wh_data_o,
  output logic [NUM_NODE_WIDTH-1:0]               wh_num_node_o,
  output logic                                    wh_src_flag_o,
  output logic [WH_ADDR_WIDTH-1:0]                wh_addr_o
);
  localparam int CRD_W = $clog2(OUT_CREDITS + 1);

  logic [CRD_W-1:0] credit_cnt;
  logic             hold_valid;
  logic             emit;

  assign emit       = hold_valid && (credit_cnt != '0);
  assign stall_o    = hold_valid && (credit_cnt == '0);
  assign wh_valid_o = emit;

  // ========================================
  // Hold slot, credits and address
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
      credit_cnt <= '0;
      wh_addr_o  <= '0;
    end else begin
      // Slot frees on emit and may refill in the same cycle
      if (!stall_o) begin
        hold_valid <= res_valid_i;
      end
      case ({out_credit_i, emit})
        2'b10: begin
          if (credit_cnt != CRD_W'(OUT_CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
          end
        end
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      if (emit) begin
        wh_addr_o <= wh_addr_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_o && res_valid_i) begin
      wh_data_o     <= res_data_i;
      wh_num_node_o <= res_num_node_i;
      wh_src_flag_o <= res_src_flag_i;
    end
  end

endmodule

// File: sources.f
logic/spmm_pkg.sv
logic/row_fetch.sv
logic/weight_lookup.sv
logic/mac_array.sv
logic/wh_writer.sv
logic/spmm_top.sv
verif/spmm_checker.sv
verif/spmm_tb.sv

// File: verif/spmm_checker.sv
// SpMM protocol checker
module spmm_checker
  import spmm_pkg::*;
#(
  parameter int IN_CREDITS  = 8,
  parameter int OUT_CREDITS = 4
) (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     in_valid_i,
  input logic                     in_credit_o,
  input logic                     out_credit_i,
  input logic                     wh_valid_o,
  input logic [WH_ADDR_WIDTH-1:0] wh_addr_o
);

  int src_cnt;
  int grant_cnt;
  int fail_cnt = 0;

  // ========================================
  // Credit mirrors
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_cnt <= IN_CREDITS;
    end else begin
      src_cnt <= src_cnt + int'(in_credit_o) - int'(in_valid_i);
    end
  end

  // Saturates at OUT_CREDITS, same as the writer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_cnt <= 0;
    end else if (out_credit_i && !wh_valid_o && grant_cnt < OUT_CREDITS) begin
      grant_cnt <= grant_cnt + 1;
    end else if (!out_credit_i && wh_valid_o) begin
      grant_cnt <= grant_cnt - 1;
    end
  end

  // ========================================
  // Assertions
  // ========================================
  // A credit returned in the same cycle may be spent at once
  a_in_credit: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i |-> (src_cnt > 0 || in_credit_o))
    else begin
      $error("in_valid_i raised with no sender credit left");
      fail_cnt++;
    end

  // Every returned credit belongs to a word still held by the buffer
  a_credit_owed: assert property (@(posedge clk) disable iff (!rst_n)
    in_credit_o |-> (src_cnt < IN_CREDITS))
    else begin
      $error("in_credit_o returned a credit for no word held");
      fail_cnt++;
    end

  a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
    wh_valid_o |-> (grant_cnt > 0))
    else begin
      $error("wh_valid_o raised with no output credit granted");
      fail_cnt++;
    end

  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> (!wh_valid_o && !in_credit_o && wh_addr_o == '0))
    else begin
      $error("outputs not in reset state after reset release");
      fail_cnt++;
    end

  a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    wh_valid_o |=> (wh_addr_o == WH_ADDR_WIDTH'($past(wh_addr_o) + 1'b1)))
    else begin
      $error("wh_addr_o did not advance by one after a result");
      fail_cnt++;
    end

  a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !wh_valid_o |=> $stable(wh_addr_o))
    else begin
      $error("wh_addr_o changed without a result");
      fail_cnt++;
    end

endmodule

// File: verif/spmm_tb.sv
// SpMM testbench
module spmm_tb
  import spmm_pkg::*;
();
  localparam int NUM_LANES   = 4;
  localparam int IN_CREDITS  = 8;
  localparam int OUT_CREDITS = 4;
  localparam int LANE_W      = $clog2(NUM_LANES);
  localparam int VEC_W       = NUM_LANES * WH_DATA_WIDTH;
  localparam int NUM_ROWS    = 150;
  localparam int HOLD_START  = 300;
  localparam int HOLD_LEN    = 400;

  logic                      clk;
  logic                      rst_n;
  logic                      in_valid_i;
  logic                      in_is_hdr_i;
  h_word_t                   in_word_i;
  logic                      in_credit_o;
  logic                      wgt_we_i;
  logic [COL_IDX_WIDTH-1:0]  wgt_row_i;
  logic [LANE_W-1:0]         wgt_lane_i;
  logic [DATA_WIDTH-1:0]     wgt_data_i;
  logic                      out_credit_i;
  logic                      wh_valid_o;
  logic [VEC_W-1:0]          wh_data_o;
  logic [NUM_NODE_WIDTH-1:0] wh_num_node_o;
  logic                      wh_src_flag_o;
  logic [WH_ADDR_WIDTH-1:0]  wh_addr_o;

  integer                    seed;
  integer                    src_seed;
  integer                    sink_seed;
  int                        wgt [NUM_FEATURE_IN][NUM_LANES];
  h_word_t                   word_q [$];
  logic                      hdr_q [$];
  logic [VEC_W-1:0]          exp_data_q [$];
  logic [NUM_NODE_WIDTH-1:0] exp_node_q [$];
  logic                      exp_flag_q [$];
  string                     exp_name_q [$];
  logic [WH_ADDR_WIDTH-1:0]  exp_addr;
  string                     cur_name;
  int                        err_cnt;
  int                        rx_cnt;
  int                        chk_fails;
  int                        watchdog_cycles;
  bit                        sink_done;

  spmm_top #(
    .NUM_LANES   (NUM_LANES),
    .IN_CREDITS  (IN_CREDITS),
    .OUT_CREDITS (OUT_CREDITS)
  ) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid_i    (in_valid_i),
    .in_is_hdr_i   (in_is_hdr_i),
    .in_word_i     (in_word_i),
    .in_credit_o   (in_credit_o),
    .wgt_we_i      (wgt_we_i),
    .wgt_row_i     (wgt_row_i),
    .wgt_lane_i    (wgt_lane_i),
    .wgt_data_i    (wgt_data_i),
    .out_credit_i  (out_credit_i),
    .wh_valid_o    (wh_valid_o),
    .wh_data_o     (wh_data_o),
    .wh_num_node_o (wh_num_node_o),
    .wh_src_flag_o (wh_src_flag_o),
    .wh_addr_o     (wh_addr_o)
  );

  bind spmm_top spmm_checker #(
    .IN_CREDITS  (IN_CREDITS),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid_i   (in_valid_i),
    .in_credit_o  (in_credit_o),
    .out_credit_i (out_credit_i),
    .wh_valid_o   (wh_valid_o),
    .wh_addr_o    (wh_addr_o)
  );

  always #10 clk = ~clk;

  // ========================================
  // Reference model
  // ========================================
  function automatic int clamp_wh(input int sum);
    int res;
    res = sum;
    if (sum > WH_MAX) begin
      res = WH_MAX;
    end else if (sum < WH_MIN) begin
      res = WH_MIN;
    end
    return res;
  endfunction

  // Mode 0 random entries, 1 drives every lane high, 2 drives every lane low
  task automatic queue_row(input string name, input int len, input int mode);
    h_word_t               w;
    int                    sum [NUM_LANES];
    int                    col;
    logic signed [7:0]     val;
    logic [VEC_W-1:0]      vec;
    logic [NUM_NODE_WIDTH-1:0] node;
    logic                  flag;
    node = NUM_NODE_WIDTH'($random(seed));
    flag = 1'($random(seed));
    w = '0;
    w.row_hdr.row_len  = ROW_LEN_WIDTH'(len);
    w.row_hdr.num_node = node;
    w.row_hdr.src_flag = flag;
    word_q.push_back(w);
    hdr_q.push_back(1'b1);
    for (int l = 0; l < NUM_LANES; l++) begin
      sum[l] = 0;
    end
    for (int e = 0; e < len; e++) begin
      col = (mode == 1) ? 14 : (mode == 2) ? 15 :
            int'($unsigned($random(seed)) % NUM_FEATURE_IN);
      val = (mode == 0) ? DATA_WIDTH'($random(seed)) : 8'sd127;
      w = '0;
      w.nz_entry.col_idx = COL_IDX_WIDTH'(col);
      w.nz_entry.val     = val;
      word_q.push_back(w);
      hdr_q.push_back(1'b0);
      for (int l = 0; l < NUM_LANES; l++) begin
        sum[l] += int'(val) * wgt[col][l];
      end
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      vec[l*WH_DATA_WIDTH +: WH_DATA_WIDTH] = WH_DATA_WIDTH'(clamp_wh(sum[l]));
    end
    exp_data_q.push_back(vec);
    exp_node_q.push_back(node);
    exp_flag_q.push_back(flag);
    exp_name_q.push_back(name);
  endtask

  // ========================================
  // Drivers
  // ========================================
  task automatic load_weights();
    for (int r = 0; r < NUM_FEATURE_IN; r++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        @(negedge clk);
        wgt_we_i   = 1'b1;
        wgt_row_i  = COL_IDX_WIDTH'(r);
        wgt_lane_i = LANE_W'(l);
        wgt_data_i = DATA_WIDTH'(wgt[r][l]);
      end
    end
    @(negedge clk);
    wgt_we_i = 1'b0;
  endtask

  task automatic drive_source();
    int credits;
    credits = IN_CREDITS;
    while (word_q.size() > 0) begin
      @(negedge clk);
      if (in_credit_o) begin
        credits++;
      end
      in_valid_i = 1'b0;
      if (credits > 0 && ($unsigned($random(src_seed)) % 8) != 0) begin
        in_valid_i  = 1'b1;
        in_is_hdr_i = hdr_q.pop_front();
        in_word_i   = word_q.pop_front();
        credits--;
      end
    end
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  // Random credit bursts, with one long window of no credits at all
  task automatic drive_sink();
    int cyc;
    int burst;
    cyc   = 0;
    burst = 0;
    while (!sink_done) begin
      @(negedge clk);
      cyc++;
      out_credit_i = 1'b0;
      if (cyc >= HOLD_START && cyc < HOLD_START + HOLD_LEN) begin
        burst = 0;
      end else if (burst > 0) begin
        out_credit_i = 1'b1;
        burst--;
      end else if (($unsigned($random(sink_seed)) % 3) == 0) begin
        burst = 1 + int'($unsigned($random(sink_seed)) % OUT_CREDITS);
      end
    end
    out_credit_i = 1'b0;
  endtask

  // ========================================
  // Result compare
  // ========================================
  task automatic check_field(input string name, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    assert (expected == actual) else begin
      err_cnt++;
      $display("** Error %s: %s expected %h actual %h", name, field, expected, actual);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && wh_valid_o) begin
      if (exp_data_q.size() == 0) begin
        err_cnt++;
        $display("Result at address %0d arrived with no row pending", wh_addr_o);
      end else begin
        cur_name = exp_name_q.pop_front();
        check_field(cur_name, "data", exp_data_q.pop_front(), wh_data_o);
        check_field(cur_name, "num_node", exp_node_q.pop_front(), wh_num_node_o);
        check_field(cur_name, "src_flag", exp_flag_q.pop_front(), wh_src_flag_o);
        check_field(cur_name, "addr", exp_addr, wh_addr_o);
        exp_addr++;
        rx_cnt++;
      end
    end
  end

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    seed         = 32'h8fd5_7caf;
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid_i   = 1'b0;
    in_is_hdr_i  = 1'b0;
    in_word_i    = '0;
    wgt_we_i     = 1'b0;
    wgt_row_i    = '0;
    wgt_lane_i   = '0;
    wgt_data_i   = '0;
    out_credit_i = 1'b0;
    exp_addr     = '0;
    err_cnt      = 0;
    rx_cnt       = 0;
    sink_done    = 1'b0;
    // Rows 14 and 15 are fixed at the extremes for overflow rows
    for (int r = 0; r < NUM_FEATURE_IN; r++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        wgt[r][l] = (r == 14) ? 127 : (r == 15) ? -128 :
                    int'($signed(DATA_WIDTH'($random(seed))));
      end
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      case (i % 12)
        5:       queue_row("zero_len", 0, 0);
        9:       queue_row("sat_pos", 1 + int'($unsigned($random(seed)) % 16), 1);
        10:      queue_row("sat_neg", 1 + int'($unsigned($random(seed)) % 16), 2);
        default: queue_row("random_rows", 1 + int'($unsigned($random(seed)) % 16), 0);
      endcase
    end
    src_seed        = seed;
    sink_seed       = ~seed;
    watchdog_cycles = NUM_ROWS * 40 + HOLD_LEN + 500;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    load_weights();
    fork
      drive_source();
      drive_sink();
    join_none
    wait (rx_cnt == NUM_ROWS);
    sink_done = 1'b1;
    // Extra results would show up here
    repeat (20) @(negedge clk);
    chk_fails = dut_i.u_chk.fail_cnt;
    $display("Errors: value %0d, assertion %0d, results %0d of %0d",
             err_cnt, chk_fails, rx_cnt, NUM_ROWS);
    if (err_cnt == 0 && chk_fails == 0 && rx_cnt == NUM_ROWS) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, %0d of %0d results, %0d value errors",
             watchdog_cycles, rx_cnt, NUM_ROWS, err_cnt);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
